// File: verilog/mips_defs.svh
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// Word width of the datapath
`define MIPS_XLEN 32

// First fetch address after reset
`define MIPS_RESET_PC 32'h0000_3000

// Destination of jal
`define MIPS_RA 5'd31

`endif

// File: verilog/mipsPkg.sv
package mipsPkg;

    ////////////////////////////////////////////////////////////
    // Instruction formats
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFmtS;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } iFmtS;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] index26;
    } jFmtS;

    // One fetched word, read as R, I or J format
    typedef union packed {
        rFmtS rFmt;
        iFmtS iFmt;
        jFmtS jFmt;
    } instrWord;

    ////////////////////////////////////////////////////////////
    // Control codes
    ////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {aluAdd, aluSub, aluXor, aluOr, aluSll, aluPassA} aluOpE;

    typedef enum logic [1:0] {extZero, extSign, extUpper} extOpE;

    typedef enum logic [1:0] {npcSeq, npcBranch, npcJump, npcReg} npcOpE;

    typedef enum logic [2:0] {wbAlu, wbWord, wbByte, wbLui, wbLink} wbSelE;

endpackage

// File: verilog/ctrlIf.sv
`timescale 1ns/100ps

interface ctrlIf;
    import mipsPkg::*;

    aluOpE       aluOp;
    extOpE       extOp;
    logic        aluSrc;     // Immediate as ALU operand
    logic        regWrite;
    logic [4:0]  regAddr;
    wbSelE       wbSel;
    npcOpE       npcOp;
    logic        isBgtz;     // Branch compare select
    logic        memWrite;

    modport ctrl (
        output aluOp, extOp, aluSrc,
        output regWrite, regAddr, wbSel,
        output npcOp, isBgtz, memWrite
    );

    modport dp (
        input aluOp, extOp, aluSrc,
        input regWrite, regAddr, wbSel,
        input npcOp, isBgtz, memWrite
    );

endinterface

// File: verilog/controller.sv
`timescale 1ns/100ps
`include "mips_defs.svh"

module controller (
    input  mipsPkg::instrWord instr,
    input  logic              rstN,
    ctrlIf.ctrl               c
);
    import mipsPkg::*;

    localparam logic [5:0] opSpecial = 6'b000000;
    localparam logic [5:0] opOri     = 6'b001101;
    localparam logic [5:0] opLw      = 6'b100011;
    localparam logic [5:0] opSw      = 6'b101011;
    localparam logic [5:0] opBeq     = 6'b000100;
    localparam logic [5:0] opLui     = 6'b001111;
    localparam logic [5:0] opJal     = 6'b000011;
    localparam logic [5:0] opJ       = 6'b000010;
    localparam logic [5:0] opLb      = 6'b100000;
    localparam logic [5:0] opBgtz    = 6'b000111;
    localparam logic [5:0] opAddi    = 6'b001000;

    logic isR;
    logic add, sub, isXor, sll, jr, jalr;
    logic ori, lw, lb, sw, beq, bgtz, lui, addi, j, jal;

    ////////////////////////////////////////////////////////////
    // One-hot instruction flags
    ////////////////////////////////////////////////////////////

    assign isR   = (instr.rFmt.opcode == opSpecial);
    assign add   = isR & (instr.rFmt.funct == 6'b100000);
    assign sub   = isR & (instr.rFmt.funct == 6'b100010);
    assign isXor = isR & (instr.rFmt.funct == 6'b100110);
    assign jr    = isR & (instr.rFmt.funct == 6'b001000);
    assign jalr  = isR & (instr.rFmt.funct == 6'b001001);
    assign sll   = isR & (instr.rFmt.funct == 6'b000000);

    assign ori  = (instr.iFmt.opcode == opOri);
    assign lw   = (instr.iFmt.opcode == opLw);
    assign lb   = (instr.iFmt.opcode == opLb);
    assign sw   = (instr.iFmt.opcode == opSw);
    assign beq  = (instr.iFmt.opcode == opBeq);
    assign bgtz = (instr.iFmt.opcode == opBgtz);
    assign lui  = (instr.iFmt.opcode == opLui);
    assign addi = (instr.iFmt.opcode == opAddi);
    assign j    = (instr.jFmt.opcode == opJ);
    assign jal  = (instr.jFmt.opcode == opJal);

    ////////////////////////////////////////////////////////////
    // Control codes
    ////////////////////////////////////////////////////////////

    assign c.aluOp = sub   ? aluSub :
                     isXor ? aluXor :
                     ori   ? aluOr :
                     sll   ? aluSll :
                     lui   ? aluPassA :
                     aluAdd;

    assign c.extOp  = (lw | lb | sw | addi) ? extSign :
                      lui ? extUpper : extZero;
    assign c.aluSrc = ori | lw | lb | sw | lui | addi;

    assign c.wbSel = lw ? wbWord :
                     lb ? wbByte :
                     lui ? wbLui :
                     (jal | jalr) ? wbLink :
                     wbAlu;

    assign c.npcOp = (beq | bgtz) ? npcBranch :
                     (j | jal) ? npcJump :
                     (jr | jalr) ? npcReg :
                     npcSeq;
    assign c.isBgtz = bgtz;

    assign c.regAddr = (add | sub | isXor | sll | jalr) ? instr.rFmt.rd :
                       (ori | lw | lb | lui | addi) ? instr.iFmt.rt :
                       jal ? `MIPS_RA : 5'd0;

    // Strobes held off while in reset
    assign c.regWrite = rstN & (add | sub | isXor | sll | jalr | jal |
                                ori | lw | lb | lui | addi);
    assign c.memWrite = rstN & sw;

endmodule

// File: verilog/regFile.sv
`timescale 1ns/100ps
`include "mips_defs.svh"

module regFile (
    input  logic                  clk,
    input  logic                  rstN,
    ctrlIf.dp                     c,
    input  logic [4:0]            rsAddr,
    input  logic [4:0]            rtAddr,
    input  logic [`MIPS_XLEN-1:0] wbData,
    output logic [`MIPS_XLEN-1:0] rsData,
    output logic [`MIPS_XLEN-1:0] rtData
);

    logic [`MIPS_XLEN-1:0] regs [1:31]; // Register 0 is not stored

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (c.regWrite && c.regAddr != 5'd0) begin
            regs[c.regAddr] <= wbData;
        end
    end

    // Old value seen on a same-cycle write
    assign rsData = (rsAddr == 5'd0) ? '0 : regs[rsAddr];
    assign rtData = (rtAddr == 5'd0) ? '0 : regs[rtAddr];

endmodule

// File: verilog/execUnit.sv
`timescale 1ns/100ps
`include "mips_defs.svh"

module execUnit (
    ctrlIf.dp                     c,
    input  logic [15:0]           imm16,
    input  logic [4:0]            shamt,
    input  logic [`MIPS_XLEN-1:0] rsData,
    input  logic [`MIPS_XLEN-1:0] rtData,
    output logic [`MIPS_XLEN-1:0] aluResult
);
    import mipsPkg::*;

    logic [`MIPS_XLEN-1:0] immExt;
    logic [`MIPS_XLEN-1:0] opA;

    ////////////////////////////////////////////////////////////
    // Immediate extension
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (c.extOp)
            extSign:  immExt = {{16{imm16[15]}}, imm16};
            extUpper: immExt = {imm16, 16'h0000};
            default:  immExt = {16'h0000, imm16};
        endcase
    end

    // Selected operand, rt data or the immediate
    assign opA = c.aluSrc ? immExt : rtData;

    ////////////////////////////////////////////////////////////
    // ALU
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (c.aluOp)
            aluSub:   aluResult = rsData - opA;
            aluXor:   aluResult = rsData ^ opA;
            aluOr:    aluResult = rsData | opA;
            aluSll:   aluResult = opA << shamt;
            aluPassA: aluResult = opA;          // lui
            default:  aluResult = rsData + opA;
        endcase
    end

endmodule

// File: verilog/pcUnit.sv
`timescale 1ns/100ps
`include "mips_defs.svh"

module pcUnit (
    input  logic                  clk,
    input  logic                  rstN,
    ctrlIf.dp                     c,
    input  logic [15:0]           imm16,
    input  logic [25:0]           index26,
    input  logic [`MIPS_XLEN-1:0] rsData,
    input  logic [`MIPS_XLEN-1:0] rtData,
    output logic [`MIPS_XLEN-1:0] pc,
    output logic [`MIPS_XLEN-1:0] pcPlus4
);
    import mipsPkg::*;

    logic                  taken;
    logic [`MIPS_XLEN-1:0] branchTarget;
    logic [`MIPS_XLEN-1:0] npc;

    assign pcPlus4 = pc + 32'd4;

    // bgtz compares rs with zero, beq compares rs with rt
    assign taken = c.isBgtz ? ($signed(rsData) > 0) : (rsData == rtData);

    assign branchTarget = pcPlus4 + {{14{imm16[15]}}, imm16, 2'b00};

    always_comb begin
        case (c.npcOp)
            npcBranch: npc = taken ? branchTarget : pcPlus4;
            npcJump:   npc = {pcPlus4[31:28], index26, 2'b00};
            npcReg:    npc = rsData;
            default:   npc = pcPlus4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= `MIPS_RESET_PC;
        end else begin
            pc <= npc;
        end
    end

endmodule

// File: verilog/writeBack.sv
`timescale 1ns/100ps
`include "mips_defs.svh"

module writeBack (
    ctrlIf.dp                     c,
    input  logic [`MIPS_XLEN-1:0] aluResult,
    input  logic [`MIPS_XLEN-1:0] memRdata,
    input  logic [`MIPS_XLEN-1:0] pcPlus4,
    output logic [`MIPS_XLEN-1:0] wbData
);
    import mipsPkg::*;

    logic [7:0] loadByte;

    // Little-endian, offset 0 is the low byte
    always_comb begin
        case (aluResult[1:0])
            2'd0:    loadByte = memRdata[7:0];
            2'd1:    loadByte = memRdata[15:8];
            2'd2:    loadByte = memRdata[23:16];
            default: loadByte = memRdata[31:24];
        endcase
    end

    always_comb begin
        case (c.wbSel)
            wbWord:  wbData = memRdata;
            wbByte:  wbData = {{24{loadByte[7]}}, loadByte};
            wbLink:  wbData = pcPlus4;
            default: wbData = aluResult;    // ALU ops and lui
        endcase
    end

endmodule

// File: verilog/mipsCore.sv
`timescale 1ns/100ps
`include "mips_defs.svh"

module mipsCore (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic [`MIPS_XLEN-1:0] instr,
    output logic [`MIPS_XLEN-1:0] pc,
    output logic [`MIPS_XLEN-1:0] memAddr,
    output logic [`MIPS_XLEN-1:0] memWdata,
    output logic                  memWrite,
    input  logic [`MIPS_XLEN-1:0] memRdata
);
    import mipsPkg::*;

    instrWord              iw;
    logic [`MIPS_XLEN-1:0] rsData;
    logic [`MIPS_XLEN-1:0] rtData;
    logic [`MIPS_XLEN-1:0] aluResult;
    logic [`MIPS_XLEN-1:0] wbData;
    logic [`MIPS_XLEN-1:0] pcPlus4;

    ctrlIf c ();

    assign iw = instr;

    controller uCtrl (.instr(iw), .rstN(rstN), .c(c.ctrl));

    regFile uRegs (
        .clk(clk), .rstN(rstN), .c(c.dp),
        .rsAddr(iw.rFmt.rs), .rtAddr(iw.rFmt.rt),
        .wbData(wbData), .rsData(rsData), .rtData(rtData)
    );

    execUnit uExec (
        .c(c.dp), .imm16(iw.iFmt.imm16), .shamt(iw.rFmt.shamt),
        .rsData(rsData), .rtData(rtData), .aluResult(aluResult)
    );

    pcUnit uPc (
        .clk(clk), .rstN(rstN), .c(c.dp),
        .imm16(iw.iFmt.imm16), .index26(iw.jFmt.index26),
        .rsData(rsData), .rtData(rtData), .pc(pc), .pcPlus4(pcPlus4)
    );

    writeBack uWb (
        .c(c.dp), .aluResult(aluResult), .memRdata(memRdata),
        .pcPlus4(pcPlus4), .wbData(wbData)
    );

    assign memAddr  = aluResult;
    assign memWdata = rtData;
    assign memWrite = c.memWrite;

endmodule

// File: test/mipsCore_properties.sv
`timescale 1ns/100ps
`include "mips_defs.svh"

module mipsCore_properties (
    input logic        clk,
    input logic        rstN,
    input logic [31:0] pc,
    input logic        memWrite
);

    ////////////////////////////////////////////////////////////
    // Port rules of the core
    ////////////////////////////////////////////////////////////

    noWriteInReset: assert property (@(posedge clk) !rstN |-> !memWrite)
        else $error("memWrite was active while reset was asserted");

    pcAligned: assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00)
        else $error("pc is not word aligned");

    // First fetch comes from the reset vector
    pcAfterReset: assert property (@(posedge clk) $rose(rstN) |-> pc == `MIPS_RESET_PC)
        else $error("pc did not start at the reset vector");

endmodule

bind mipsCore mipsCore_properties uProps (
    .clk(clk), .rstN(rstN), .pc(pc), .memWrite(memWrite)
);

// File: test/mipsCoreTb.sv
`timescale 1ns/100ps
`include "mips_defs.svh"

module mipsCoreTb;

    localparam int maxCycles = 5 * (10 + 64) + 40;

    logic        clk;
    logic        rstN;
    logic [31:0] instr, pc, memAddr, memWdata, memRdata;
    logic        memWrite;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    logic [31:0] dmemInit [256];        // Data image loaded during reset
    logic [31:0] mRegs [32];
    logic [31:0] mDmem [256];
    logic [31:0] mPc, prevPc, expAddr, expWdata;
    logic        expWrite, expAccess, running, done;
    logic [31:0] lfsr = 32'd50;
    logic [7:0]  wp;
    int          errors = 0, testErrs = 0, testCycles = 0, totalCycles = 0, failedTests = 0;
    string       testNames [5] = '{"reset and sequence", "arithmetic", "loads", "branches",
                                   "jumps"};

    mipsCore i_dut (.clk(clk), .rstN(rstN), .instr(instr), .pc(pc), .memAddr(memAddr),
                    .memWdata(memWdata), .memWrite(memWrite), .memRdata(memRdata));

    always #20 clk = ~clk;

    assign instr    = imem[pc[9:2]];
    assign memRdata = dmem[memAddr[9:2]];

    always @(posedge clk) begin
        if (!rstN) dmem <= dmemInit;
        else if (memWrite) dmem[memAddr[9:2]] <= memWdata;
    end

    ////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [31:0] rType(input logic [4:0] rs, rt, rd, sh, input logic [5:0] fn);
        return {6'd0, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] iType(input logic [5:0] op, input logic [4:0] rs, rt,
                                          input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jType(input logic [5:0] op, input logic [31:0] target);
        return {op, target[27:2]};
    endfunction

    function automatic logic [31:0] pcAt(input logic [7:0] k);
        return `MIPS_RESET_PC + {22'd0, k, 2'b00};
    endfunction

    task automatic emit(input logic [31:0] w);
        imem[wp] = w;
        wp++;
    endtask

    task automatic buildProgram(input int t);
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;                                   // sll r0 acts as nop
            dmemInit[i] = randBits(32);
        end
        dmemInit[16] = (dmemInit[16] | 32'h8000_0000) & 32'hFFFF_FF7F;  // Both byte signs
        wp = 8'd0;
        case (t)
            0: begin
                emit(iType(6'd13, 5'd0, 5'd1, 16'(randBits(16))));
                emit(iType(6'd13, 5'd1, 5'd2, 16'(randBits(16))));
                emit(iType(6'd43, 5'd0, 5'd1, 16'h0000));
                emit(iType(6'd43, 5'd0, 5'd2, 16'h0004));
            end
            1: begin
                emit(iType(6'd15, 5'd0, 5'd1, 16'(randBits(16))));
                emit(iType(6'd13, 5'd1, 5'd1, 16'(randBits(16))));
                emit(iType(6'd15, 5'd0, 5'd2, 16'(randBits(16))));
                emit(iType(6'd13, 5'd2, 5'd2, 16'(randBits(16))));
                emit(rType(5'd1, 5'd2, 5'd3, 5'd0, 6'd32));     // add
                emit(rType(5'd1, 5'd2, 5'd4, 5'd0, 6'd34));     // sub
                emit(rType(5'd1, 5'd2, 5'd5, 5'd0, 6'd38));     // xor
                emit(rType(5'd0, 5'd1, 5'd6, 5'(randBits(5)), 6'd0));
                emit(iType(6'd8, 5'd1, 5'd7, 16'(randBits(16))));
                for (int r = 3; r <= 7; r++) emit(iType(6'd43, 5'd0, 5'(r), 16'(r * 4)));
            end
            2: begin
                emit(iType(6'd13, 5'd0, 5'd1, 16'h0040));
                for (int off = 0; off < 4; off++) begin
                    emit(iType(6'd32, 5'd1, 5'd2, 16'(off)));
                    emit(iType(6'd43, 5'd0, 5'd2, 16'(8'h80 + off * 4)));
                end
                emit(iType(6'd35, 5'd1, 5'd3, 16'h0004));
                emit(iType(6'd43, 5'd0, 5'd3, 16'h0090));
                emit(iType(6'd35, 5'd1, 5'd0, 16'h0008));    // Load into r0
                emit(iType(6'd43, 5'd0, 5'd0, 16'h0094));
            end
            3: begin
                emit(iType(6'd13, 5'd0, 5'd1, 16'h5A5A));
                emit(iType(6'd13, 5'd0, 5'd2, 16'h5A5A));
                emit(iType(6'd15, 5'd0, 5'd3, 16'h8000));
                emit(iType(6'd4, 5'd1, 5'd2, 16'd1));         // Taken
                emit(iType(6'd13, 5'd0, 5'd10, 16'd1));
                emit(iType(6'd4, 5'd1, 5'd3, 16'd1));         // Not taken
                emit(iType(6'd13, 5'd0, 5'd11, 16'd2));
                emit(iType(6'd7, 5'd3, 5'd0, 16'd1));         // Negative
                emit(iType(6'd13, 5'd0, 5'd12, 16'd3));
                emit(iType(6'd7, 5'd0, 5'd0, 16'd1));         // Zero
                emit(iType(6'd13, 5'd0, 5'd13, 16'd4));
                emit(iType(6'd7, 5'd1, 5'd0, 16'd1));         // Positive
                emit(iType(6'd13, 5'd0, 5'd14, 16'd5));
                for (int r = 10; r <= 14; r++) emit(iType(6'd43, 5'd0, 5'(r), 16'(r * 4)));
            end
            default: begin
                emit(jType(6'd2, pcAt(8'd2)));
                emit(iType(6'd13, 5'd0, 5'd10, 16'd1));
                emit(jType(6'd3, pcAt(8'd6)));
                emit(iType(6'd13, 5'd0, 5'd5, 16'(pcAt(8'd9))));
                emit(rType(5'd5, 5'd0, 5'd30, 5'd0, 6'd9));   // jalr r30
                emit(iType(6'd13, 5'd0, 5'd11, 16'd2));
                emit(iType(6'd43, 5'd0, 5'd31, 16'h0030));
                emit(rType(5'd31, 5'd0, 5'd0, 5'd0, 6'd8));   // jr r31
                emit(iType(6'd13, 5'd0, 5'd12, 16'd3));
                emit(iType(6'd43, 5'd0, 5'd30, 16'h0034));
                emit(iType(6'd43, 5'd0, 5'd10, 16'h0038));
            end
        endcase
        emit(jType(6'd2, pcAt(wp)));                        // Halt loop
    endtask

    ////////////////////////////////////////////////////////////
    // Reference model and checking
    ////////////////////////////////////////////////////////////

    function automatic void setReg(input logic [4:0] r, input logic [31:0] v);
        if (r != 5'd0) mRegs[r] = v;
    endfunction

    function automatic void refStep();
        logic [31:0] ir, a, b, simm, np, w;
        logic [4:0]  rs, rt, rd;
        ir = imem[mPc[9:2]];
        rs = ir[25:21];
        rt = ir[20:16];
        rd = ir[15:11];
        a = mRegs[rs];
        b = mRegs[rt];
        simm = {{16{ir[15]}}, ir[15:0]};
        np = mPc + 32'd4;
        expWrite = 1'b0;
        expAccess = 1'b0;
        expAddr = a + simm;
        expWdata = b;
        case (ir[31:26])
            6'd0: case (ir[5:0])
                6'd32: setReg(rd, a + b);
                6'd34: setReg(rd, a - b);
                6'd38: setReg(rd, a ^ b);
                6'd0:  setReg(rd, b << ir[10:6]);
                6'd8:  np = a;
                6'd9: begin
                    setReg(rd, mPc + 32'd4);
                    np = a;
                end
                default: ;
            endcase
            6'd13: setReg(rt, a | {16'h0000, ir[15:0]});
            6'd8:  setReg(rt, a + simm);
            6'd15: setReg(rt, {ir[15:0], 16'h0000});
            6'd35: begin
                expAccess = 1'b1;
                setReg(rt, mDmem[expAddr[9:2]]);
            end
            6'd32: begin
                expAccess = 1'b1;
                w = mDmem[expAddr[9:2]] >> {expAddr[1:0], 3'b000};
                setReg(rt, {{24{w[7]}}, w[7:0]});
            end
            6'd43: begin
                expAccess = 1'b1;
                expWrite = 1'b1;
                mDmem[expAddr[9:2]] = b;
            end
            6'd4:  if (a == b) np = np + (simm << 2);
            6'd7:  if ($signed(a) > 32'sd0) np = np + (simm << 2);
            6'd2:  np = {np[31:28], ir[25:0], 2'b00};
            6'd3: begin
                setReg(`MIPS_RA, mPc + 32'd4);
                np = {np[31:28], ir[25:0], 2'b00};
            end
            default: ;
        endcase
        mPc = np;
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
            testErrs++;
        end
    endtask

    always @(posedge clk) begin
        if (!running) begin                  // Model reset
            mPc = `MIPS_RESET_PC;
            mRegs = '{default: '0};
            mDmem = dmemInit;
            testErrs = 0;
            testCycles = 0;
            done = 1'b0;
        end else if (!done) begin
            prevPc = mPc;
            refStep();
            check(pc, prevPc, "pc");
            check({31'd0, memWrite}, {31'd0, expWrite}, "memWrite");
            if (expAccess) check(memAddr, expAddr, "memAddr");
            if (expWrite) check(memWdata, expWdata, "memWdata");
            testCycles++;
            if (mPc == prevPc) done = 1'b1;
        end
    end

    always @(posedge clk) begin
        totalCycles++;
        if (totalCycles > maxCycles) begin
            $display("Timeout: the run went past %0d cycles", maxCycles);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        clk = 1'b0;
        rstN = 1'b0;
        running = 1'b0;
        for (int t = 0; t < 5; t++) begin
            @(negedge clk);
            rstN = 1'b0;
            running = 1'b0;
            buildProgram(t);
            repeat (10) @(negedge clk);
            rstN = 1'b1;
            running = 1'b1;
            wait (done);
            @(negedge clk);
            running = 1'b0;
            if (testErrs != 0) failedTests++;
            $display("Test %0d (%s): %s after %0d cycles, %0d errors", t, testNames[t],
                     (testErrs == 0) ? "ok" : "FAILED", testCycles, testErrs);
        end
        $display("Tests run: 5, failed: %0d, errors: %0d", failedTests, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+verilog
verilog/mipsPkg.sv
verilog/ctrlIf.sv
verilog/controller.sv
verilog/regFile.sv
verilog/execUnit.sv
verilog/pcUnit.sv
verilog/writeBack.sv
verilog/mipsCore.sv
test/mipsCore_properties.sv
test/mipsCoreTb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert --timescale 1ns/100ps
TOP       = mipsCoreTb
FILELIST  = files.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
